/* noc_mesh2d.f */
hdl/noc_pkg.sv
hdl/noc_input_fifo.sv
hdl/noc_route_decode.sv
hdl/noc_switch_arbiter.sv
hdl/noc_output_reg.sv
hdl/noc_router.sv
hdl/noc_mesh2d.sv
verif/tb_noc_mesh2d.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the mesh testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
  --top-module tb_noc_mesh2d \
  -f noc_mesh2d.f \
  -o sim_tb_noc_mesh2d

./obj_dir/sim_tb_noc_mesh2d | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
  exit 0
else
  exit 1
fi

/* verif/noc_testdata.txt */
# Packet list for the 2x2 mesh, node number = x + 2 * y
# src_node dst_node data_flits first_word(hex) tag(hex)
0 3 4 10000000 a001
1 2 3 20000000 b001
2 1 5 30000000 c001
3 0 2 40000000 d001
0 1 1 10000100 a002
1 1 3 20000100 b002
2 3 6 30000100 c002
3 3 2 40000100 d002
0 3 5 10000200 a003
2 3 4 30000200 c003
1 3 3 20000200 b003
3 2 1 40000200 d003
0 0 2 10000300 a004
1 0 4 20000300 b004
2 0 3 30000300 c004
3 1 6 40000300 d004
0 2 3 10000400 a005
1 3 2 20000400 b005
2 2 1 30000400 c005
3 0 5 40000400 d005
0 3 6 10000500 a006
1 2 4 20000500 b006
2 1 2 30000500 c006
3 3 3 40000500 d006
0 1 4 10000600 a007
2 3 3 30000600 c007
3 2 4 fffffffe d007

/* verif/tb_noc_mesh2d.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_noc_mesh2d import noc_pkg::*; ();

  localparam int X_NODES      = 2;
  localparam int Y_NODES      = 2;
  localparam int NODES        = X_NODES * Y_NODES;
  localparam int BUFFER_DEPTH = 4;
  localparam int MAX_PKTS     = 64;
  localparam int RUN_LIMIT    = 20000;
  localparam int READY_LIMIT  = 10;
  localparam int DRAIN_CYCLES = 50;

  logic              clk;
  logic              rst_n;
  flit_t [NODES-1:0] in_flit;
  logic  [NODES-1:0] in_valid;
  logic  [NODES-1:0] in_ready;
  flit_t [NODES-1:0] out_flit;
  logic  [NODES-1:0] out_valid;
  logic  [NODES-1:0] out_ready;

  // Packet table from the data file
  int          num_pkts;
  int          pkt_src  [MAX_PKTS];
  int          pkt_dst  [MAX_PKTS];
  int          pkt_len  [MAX_PKTS];
  logic [31:0] pkt_word [MAX_PKTS];
  logic [15:0] pkt_tag  [MAX_PKTS];

  // Packets still to send per source, still expected per destination and source
  int src_q [NODES][$];
  int exp_q [NODES][NODES][$];

  int          flit_idx [NODES];
  int          gap      [NODES];
  int          rx_pkt   [NODES];
  int          rx_idx   [NODES];
  logic [NODES-1:0] in_acc;
  int          sent_pkts;
  int          rcvd_pkts;
  int          check_errors;
  int          other_errors;
  logic [31:0] lfsr_state;

  noc_mesh2d #(
    .X_NODES      (X_NODES),
    .Y_NODES      (Y_NODES),
    .BUFFER_DEPTH (BUFFER_DEPTH)
  ) uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_flit   (in_flit),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_flit  (out_flit),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////
  // Helpers

  // Galois LFSR, taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return b;
  endfunction

  function automatic int rand_bits(input int width);
    int v;
    v = 0;
    for (int i = 0; i < width; i++) begin
      v = (v << 1) | int'(lfsr_bit());
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED: %s expected %08h actual %08h", name, expected, actual);
      check_errors++;
    end
  endtask

  task automatic load_packets();
    int    fd;
    int    cnt;
    int    s;
    int    d;
    int    l;
    logic [31:0] w;
    logic [15:0] t;
    string line;
    fd = $fopen("verif/noc_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open the packet file verif/noc_testdata.txt");
      other_errors++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() == 0 || line.getc(0) == "#") continue;
      cnt = $sscanf(line, "%d %d %d %h %h", s, d, l, w, t);
      if (cnt != 5) continue;
      if (s < 0 || s >= NODES || d < 0 || d >= NODES || l < 1 || num_pkts >= MAX_PKTS) begin
        $display("Skipping a bad packet entry in the packet file");
        other_errors++;
        continue;
      end
      pkt_src[num_pkts]  = s;
      pkt_dst[num_pkts]  = d;
      pkt_len[num_pkts]  = l;
      pkt_word[num_pkts] = w;
      pkt_tag[num_pkts]  = t;
      src_q[s].push_back(num_pkts);
      exp_q[d][s].push_back(num_pkts);
      num_pkts++;
    end
    $fclose(fd);
    if (num_pkts == 0) begin
      $display("The packet file holds no packets");
      other_errors++;
    end
  endtask

  // Index 0 is the header, then data words counting up from the first
  function automatic flit_t make_flit(input int p, input int idx);
    flit_t f;
    f = '0;
    if (idx == 0) begin
      f.word.hdr.dst_x = COORD_W'(pkt_dst[p] % X_NODES);
      f.word.hdr.dst_y = COORD_W'(pkt_dst[p] / X_NODES);
      f.word.hdr.src_x = COORD_W'(pkt_src[p] % X_NODES);
      f.word.hdr.src_y = COORD_W'(pkt_src[p] / X_NODES);
      f.word.hdr.tag   = pkt_tag[p];
    end else begin
      f.word.data = pkt_word[p] + 32'(idx - 1);
      f.last      = (idx == pkt_len[p]);
    end
    return f;
  endfunction

  ////////////////////
  // Driver and scoreboard

  task automatic drive_step(input int n);
    int p;
    // Flit offered but not taken, hold it
    if (in_valid[n] && !in_acc[n]) return;
    if (in_valid[n]) begin
      if (flit_idx[n] == pkt_len[src_q[n][0]]) begin
        p = src_q[n].pop_front();
        flit_idx[n] = 0;
        gap[n] = rand_bits(2);
        sent_pkts++;
      end else begin
        flit_idx[n]++;
      end
    end
    in_valid[n] = 1'b0;
    if (gap[n] > 0) begin
      gap[n]--;
    end else if (src_q[n].size() > 0) begin
      p = src_q[n][0];
      in_flit[n]  = make_flit(p, flit_idx[n]);
      in_valid[n] = 1'b1;
    end
  endtask

  task automatic check_flit(input int n, input flit_t f);
    int p;
    int s;
    if (rx_pkt[n] < 0) begin
      s = int'(f.word.hdr.src_x) + int'(f.word.hdr.src_y) * X_NODES;
      check_value($sformatf("node %0d header dst_x", n), 32'(n % X_NODES),
                  32'(f.word.hdr.dst_x));
      check_value($sformatf("node %0d header dst_y", n), 32'(n / X_NODES),
                  32'(f.word.hdr.dst_y));
      if (s >= NODES || exp_q[n][s].size() == 0) begin
        $display("Node %0d received a packet nobody sent it, source field %0d", n, s);
        other_errors++;
        return;
      end
      // Oldest outstanding packet from that source must come first
      p = exp_q[n][s].pop_front();
      rx_pkt[n] = p;
      rx_idx[n] = 1;
      check_value($sformatf("pkt %0d tag", p), 32'(pkt_tag[p]), 32'(f.word.hdr.tag));
      check_value($sformatf("pkt %0d header last", p), 32'd0, 32'(f.last));
    end else begin
      p = rx_pkt[n];
      check_value($sformatf("pkt %0d data %0d", p, rx_idx[n]),
                  pkt_word[p] + 32'(rx_idx[n] - 1), f.word.data);
      check_value($sformatf("pkt %0d last on flit %0d", p, rx_idx[n]),
                  32'(rx_idx[n] == pkt_len[p]), 32'(f.last));
      if (f.last) begin
        rx_pkt[n] = -1;
        rcvd_pkts++;
      end else begin
        rx_idx[n]++;
      end
    end
  endtask

  ////////////////////
  // Main sequence

  initial begin
    int cycles;
    int waited;
    rst_n        = 1'b0;
    in_flit      = '0;
    in_valid     = '0;
    out_ready    = '0;
    in_acc       = '0;
    lfsr_state   = 32'd83520;
    num_pkts     = 0;
    sent_pkts    = 0;
    rcvd_pkts    = 0;
    check_errors = 0;
    other_errors = 0;
    for (int n = 0; n < NODES; n++) begin
      flit_idx[n] = 0;
      gap[n]      = 0;
      rx_pkt[n]   = -1;
      rx_idx[n]   = 0;
    end
    load_packets();

    // Three reset edges, outputs must stay quiet
    @(posedge clk);
    repeat (2) begin
      @(negedge clk);
      check_value("out_valid during reset", 32'd0, 32'(out_valid));
      @(posedge clk);
    end
    #1 rst_n = 1'b1;

    waited = 0;
    @(negedge clk);
    check_value("out_valid after reset", 32'd0, 32'(out_valid));
    while (in_ready != '1 && waited < READY_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (in_ready != '1) begin
      $display("Timeout: in_ready did not come up at every node after reset");
      other_errors++;
    end

    cycles = 0;
    while (!(sent_pkts == num_pkts && rcvd_pkts == num_pkts) && cycles < RUN_LIMIT) begin
      @(posedge clk);
      #1;
      for (int n = 0; n < NODES; n++) begin
        drive_step(n);
        out_ready[n] = (rand_bits(2) != 0);
      end
      @(negedge clk);
      for (int n = 0; n < NODES; n++) begin
        in_acc[n] = in_valid[n] && in_ready[n];
        if (out_valid[n] && out_ready[n]) begin
          check_flit(n, out_flit[n]);
        end
      end
      cycles++;
    end
    if (cycles >= RUN_LIMIT) begin
      $display("Timeout: %0d of %0d packets sent, %0d delivered", sent_pkts, num_pkts,
               rcvd_pkts);
      other_errors++;
    end

    // Nothing more may come out once every packet is in
    @(posedge clk);
    #1 out_ready = '1;
    for (int c = 0; c < DRAIN_CYCLES; c++) begin
      @(negedge clk);
      if (out_valid != '0) begin
        $display("Extra flit seen at the outputs, out_valid %b", out_valid);
        other_errors++;
      end
    end

    $display("Errors: %0d value mismatches, %0d other failures", check_errors, other_errors);
    if (check_errors == 0 && other_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/noc_mesh2d.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_mesh2d import noc_pkg::*; #(
  parameter int  X_NODES      = 2,
  parameter int  Y_NODES      = 2,
  parameter int  BUFFER_DEPTH = 4,
  localparam int NODES        = X_NODES * Y_NODES
) (
  input  logic              clk,
  input  logic              rst_n,

  // Local port of each node, indexed x + y * X_NODES
  input  flit_t [NODES-1:0] in_flit,
  input  logic  [NODES-1:0] in_valid,
  output logic  [NODES-1:0] in_ready,

  output flit_t [NODES-1:0] out_flit,
  output logic  [NODES-1:0] out_valid,
  input  logic  [NODES-1:0] out_ready
);

  wire flit_t [NUM_PORTS-1:0] node_in_flit   [NODES];
  wire logic  [NUM_PORTS-1:0] node_in_valid  [NODES];
  wire logic  [NUM_PORTS-1:0] node_in_ready  [NODES];
  wire flit_t [NUM_PORTS-1:0] node_out_flit  [NODES];
  wire logic  [NUM_PORTS-1:0] node_out_valid [NODES];
  wire logic  [NUM_PORTS-1:0] node_out_ready [NODES];

  for (genvar y = 0; y < Y_NODES; y++) begin : g_y
    for (genvar x = 0; x < X_NODES; x++) begin : g_x
      localparam int N = x + y * X_NODES;

      noc_router #(
        .X_POS        (x),
        .Y_POS        (y),
        .BUFFER_DEPTH (BUFFER_DEPTH)
      ) u_router (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_flit   (node_in_flit[N]),
        .in_valid  (node_in_valid[N]),
        .in_ready  (node_in_ready[N]),
        .out_flit  (node_out_flit[N]),
        .out_valid (node_out_valid[N]),
        .out_ready (node_out_ready[N])
      );

      // Local port to the top-level pins
      assign node_in_flit[N][PORT_LOCAL]   = in_flit[N];
      assign node_in_valid[N][PORT_LOCAL]  = in_valid[N];
      assign in_ready[N]                   = node_in_ready[N][PORT_LOCAL];
      assign out_flit[N]                   = node_out_flit[N][PORT_LOCAL];
      assign out_valid[N]                  = node_out_valid[N][PORT_LOCAL];
      assign node_out_ready[N][PORT_LOCAL] = out_ready[N];

      ////////////////////
      // East and west neighbours

      if (x < X_NODES - 1) begin : g_east
        assign node_in_flit[N][PORT_EAST]   = node_out_flit[N+1][PORT_WEST];
        assign node_in_valid[N][PORT_EAST]  = node_out_valid[N+1][PORT_WEST];
        assign node_out_ready[N][PORT_EAST] = node_in_ready[N+1][PORT_WEST];
      end else begin : g_east_edge
        assign node_in_flit[N][PORT_EAST]   = '0;
        assign node_in_valid[N][PORT_EAST]  = 1'b0;
        assign node_out_ready[N][PORT_EAST] = 1'b0;
      end

      if (x > 0) begin : g_west
        assign node_in_flit[N][PORT_WEST]   = node_out_flit[N-1][PORT_EAST];
        assign node_in_valid[N][PORT_WEST]  = node_out_valid[N-1][PORT_EAST];
        assign node_out_ready[N][PORT_WEST] = node_in_ready[N-1][PORT_EAST];
      end else begin : g_west_edge
        assign node_in_flit[N][PORT_WEST]   = '0;
        assign node_in_valid[N][PORT_WEST]  = 1'b0;
        assign node_out_ready[N][PORT_WEST] = 1'b0;
      end

      ////////////////////
      // North is y + 1

      if (y < Y_NODES - 1) begin : g_north
        assign node_in_flit[N][PORT_NORTH]   = node_out_flit[N+X_NODES][PORT_SOUTH];
        assign node_in_valid[N][PORT_NORTH]  = node_out_valid[N+X_NODES][PORT_SOUTH];
        assign node_out_ready[N][PORT_NORTH] = node_in_ready[N+X_NODES][PORT_SOUTH];
      end else begin : g_north_edge
        assign node_in_flit[N][PORT_NORTH]   = '0;
        assign node_in_valid[N][PORT_NORTH]  = 1'b0;
        assign node_out_ready[N][PORT_NORTH] = 1'b0;
      end

      if (y > 0) begin : g_south
        assign node_in_flit[N][PORT_SOUTH]   = node_out_flit[N-X_NODES][PORT_NORTH];
        assign node_in_valid[N][PORT_SOUTH]  = node_out_valid[N-X_NODES][PORT_NORTH];
        assign node_out_ready[N][PORT_SOUTH] = node_in_ready[N-X_NODES][PORT_NORTH];
      end else begin : g_south_edge
        assign node_in_flit[N][PORT_SOUTH]   = '0;
        assign node_in_valid[N][PORT_SOUTH]  = 1'b0;
        assign node_out_ready[N][PORT_SOUTH] = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/noc_router.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_router import noc_pkg::*; #(
  parameter int X_POS        = 0,
  parameter int Y_POS        = 0,
  parameter int BUFFER_DEPTH = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,

  input  flit_t [NUM_PORTS-1:0] in_flit,
  input  logic  [NUM_PORTS-1:0] in_valid,
  output logic  [NUM_PORTS-1:0] in_ready,

  output flit_t [NUM_PORTS-1:0] out_flit,
  output logic  [NUM_PORTS-1:0] out_valid,
  input  logic  [NUM_PORTS-1:0] out_ready
);

  flit_t     [NUM_PORTS-1:0] head_flit;
  logic      [NUM_PORTS-1:0] head_valid;
  logic      [NUM_PORTS-1:0] pop;
  port_req_t [NUM_PORTS-1:0] req;

  // Switch side of the output stages
  flit_t     [NUM_PORTS-1:0] xbar_flit;
  logic      [NUM_PORTS-1:0] xbar_valid;
  logic      [NUM_PORTS-1:0] xbar_ready;

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    // Buffer stage
    noc_input_fifo #(
      .BUFFER_DEPTH (BUFFER_DEPTH)
    ) u_fifo (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_flit    (in_flit[p]),
      .in_valid   (in_valid[p]),
      .in_ready   (in_ready[p]),
      .head_flit  (head_flit[p]),
      .head_valid (head_valid[p]),
      .pop        (pop[p])
    );

    // Decode stage
    noc_route_decode #(
      .X_POS (X_POS),
      .Y_POS (Y_POS)
    ) u_decode (
      .clk        (clk),
      .rst_n      (rst_n),
      .head_flit  (head_flit[p]),
      .head_valid (head_valid[p]),
      .pop        (pop[p]),
      .req        (req[p])
    );

    // Result stage
    noc_output_reg u_out (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_flit   (xbar_flit[p]),
      .in_valid  (xbar_valid[p]),
      .in_ready  (xbar_ready[p]),
      .out_flit  (out_flit[p]),
      .out_valid (out_valid[p]),
      .out_ready (out_ready[p])
    );
  end

  // Execute stage
  noc_switch_arbiter u_switch (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .in_flit   (head_flit),
    .pop       (pop),
    .out_flit  (xbar_flit),
    .out_valid (xbar_valid),
    .out_ready (xbar_ready)
  );

endmodule

`default_nettype wire

/* hdl/noc_output_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_output_reg import noc_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,

  input  flit_t in_flit,
  input  logic  in_valid,
  output logic  in_ready,

  output flit_t out_flit,
  output logic  out_valid,
  input  logic  out_ready
);

  flit_t data_q;
  logic  full_q;

  // Room when empty or when the held flit leaves this cycle
  assign in_ready = !full_q || out_ready;

  assign out_flit  = data_q;
  assign out_valid = full_q;

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      data_q <= in_flit;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      full_q <= 1'b0;
    end else if (in_valid && in_ready) begin
      full_q <= 1'b1;
    end else if (out_ready) begin
      full_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* hdl/noc_switch_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_switch_arbiter import noc_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,

  // One request vector and head flit per input
  input  port_req_t [NUM_PORTS-1:0] req,
  input  flit_t     [NUM_PORTS-1:0] in_flit,
  output logic      [NUM_PORTS-1:0] pop,

  // Granted flit per output
  output flit_t     [NUM_PORTS-1:0] out_flit,
  output logic      [NUM_PORTS-1:0] out_valid,
  input  logic      [NUM_PORTS-1:0] out_ready
);

  localparam int IDX_W = $clog2(NUM_PORTS);

  ////////////////////
  // Per-output state

  logic [NUM_PORTS-1:0] lock_valid;
  logic [IDX_W-1:0]     lock_owner [NUM_PORTS];
  logic [IDX_W-1:0]     rr_ptr     [NUM_PORTS];

  logic [NUM_PORTS-1:0] grant_valid;
  logic [IDX_W-1:0]     grant_idx  [NUM_PORTS];
  logic [NUM_PORTS-1:0] xfer;

  ////////////////////
  // Arbitration

  // A locked output only serves its owner, otherwise search after the pointer
  always_comb begin
    int cand;
    cand = 0;
    for (int o = 0; o < NUM_PORTS; o++) begin
      grant_valid[o] = 1'b0;
      grant_idx[o]   = lock_owner[o];
      if (lock_valid[o]) begin
        grant_valid[o] = req[lock_owner[o]][o];
      end else begin
        for (int k = 1; k <= NUM_PORTS; k++) begin
          cand = (int'(rr_ptr[o]) + k) % NUM_PORTS;
          if (!grant_valid[o] && req[cand][o]) begin
            grant_valid[o] = 1'b1;
            grant_idx[o]   = IDX_W'(cand);
          end
        end
      end
    end
  end

  assign xfer = grant_valid & out_ready;

  ////////////////////
  // Crossbar

  always_comb begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      out_flit[o] = in_flit[grant_idx[o]];
    end
  end

  assign out_valid = grant_valid;

  // Requests are one-hot, so each input moves through at most one output
  always_comb begin
    pop = '0;
    for (int o = 0; o < NUM_PORTS; o++) begin
      if (xfer[o]) begin
        pop[grant_idx[o]] = 1'b1;
      end
    end
  end

  ////////////////////
  // Wormhole lock

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lock_valid <= '0;
      for (int o = 0; o < NUM_PORTS; o++) begin
        lock_owner[o] <= '0;
        rr_ptr[o]     <= '0;
      end
    end else begin
      for (int o = 0; o < NUM_PORTS; o++) begin
        if (xfer[o]) begin
          if (out_flit[o].last) begin
            // Packet done, the owner drops to lowest priority
            lock_valid[o] <= 1'b0;
            rr_ptr[o]     <= grant_idx[o];
          end else begin
            lock_valid[o] <= 1'b1;
            lock_owner[o] <= grant_idx[o];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/noc_route_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_route_decode import noc_pkg::*; #(
  parameter int X_POS = 0,
  parameter int Y_POS = 0
) (
  input  logic      clk,
  input  logic      rst_n,

  input  flit_t     head_flit,
  input  logic      head_valid,
  input  logic      pop,

  output port_req_t req
);

  flit_header_t hdr;
  port_req_t    route_req;
  port_req_t    held_req;
  logic         expect_header;

  assign hdr = head_flit.word.hdr;

  // XY order: finish the x offset first, then y
  always_comb begin
    route_req = '0;
    if (hdr.dst_x > COORD_W'(X_POS)) begin
      route_req[PORT_EAST] = 1'b1;
    end else if (hdr.dst_x < COORD_W'(X_POS)) begin
      route_req[PORT_WEST] = 1'b1;
    end else if (hdr.dst_y > COORD_W'(Y_POS)) begin
      route_req[PORT_NORTH] = 1'b1;
    end else if (hdr.dst_y < COORD_W'(Y_POS)) begin
      route_req[PORT_SOUTH] = 1'b1;
    end else begin
      route_req[PORT_LOCAL] = 1'b1;
    end
  end

  // Data flits follow the route their header picked
  assign req = !head_valid ? '0 : (expect_header ? route_req : held_req);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      expect_header <= 1'b1;
      held_req      <= '0;
    end else if (pop) begin
      // The flit after a last is the next header
      expect_header <= head_flit.last;
      if (head_flit.last) begin
        held_req <= '0;
      end else if (expect_header) begin
        held_req <= route_req;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/noc_input_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_input_fifo import noc_pkg::*; #(
  parameter int BUFFER_DEPTH = 4
) (
  input  logic  clk,
  input  logic  rst_n,

  input  flit_t in_flit,
  input  logic  in_valid,
  output logic  in_ready,

  output flit_t head_flit,
  output logic  head_valid,
  input  logic  pop
);

  localparam int PTR_W = (BUFFER_DEPTH > 1) ? $clog2(BUFFER_DEPTH) : 1;
  localparam int CNT_W = $clog2(BUFFER_DEPTH + 1);

  flit_t            mem [BUFFER_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             drop;

  assign in_ready   = (count != CNT_W'(BUFFER_DEPTH));
  assign head_valid = (count != '0);
  assign head_flit  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  // Pop is only meaningful while something is buffered
  assign drop = pop && head_valid;

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_flit;
    end
  end

  // Pointers wrap at the buffer depth, which need not be a power of two
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(BUFFER_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (drop) begin
        rd_ptr <= (rd_ptr == PTR_W'(BUFFER_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !drop) begin
        count <= count + 1'b1;
      end else if (drop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/noc_pkg.sv */
`default_nettype none

package noc_pkg;

  ////////////////////
  // Sizes

  // Width of one data word in a flit
  localparam int FLIT_WIDTH = 32;

  // Width of one mesh coordinate
  localparam int COORD_W = 4;

  // Local plus four neighbours
  localparam int NUM_PORTS = 5;

  ////////////////////
  // Port indexes

  // Used for the wiring arrays and for the one-hot request bits
  localparam int PORT_LOCAL = 0;
  localparam int PORT_NORTH = 1;
  localparam int PORT_EAST  = 2;
  localparam int PORT_SOUTH = 3;
  localparam int PORT_WEST  = 4;

  ////////////////////
  // Flit types

  // One-hot output select, zero when nothing is requested
  typedef logic [NUM_PORTS-1:0] port_req_t;

  // First flit of a packet
  typedef struct packed {
    logic [COORD_W-1:0] dst_x;
    logic [COORD_W-1:0] dst_y;
    logic [COORD_W-1:0] src_x;
    logic [COORD_W-1:0] src_y;
    logic [15:0]        tag;
  } flit_header_t;

  // Same word, read as a header or as payload
  typedef union packed {
    flit_header_t          hdr;
    logic [FLIT_WIDTH-1:0] data;
  } flit_word_u;

  // Link payload
  typedef struct packed {
    flit_word_u word;
    logic       last;
  } flit_t;

endpackage

`default_nettype wire
